// File: memtest_params.svh
/*
 * Widths and fixed AXI burst geometry for the memory pattern tester.
 * Included by the packages and by every RTL file that needs a width.
 */
`ifndef MEMTEST_PARAMS_SVH
`define MEMTEST_PARAMS_SVH

// datapath and address widths
`define MT_DATA_W       64
`define MT_ADDR_W       32

// burst geometry, beats cut down from 256 for simulation
`define MT_BEATS        16
`define MT_AXLEN        (`MT_BEATS - 1)
`define MT_AXSIZE       3
`define MT_BEAT_BYTES   8
`define MT_BURST_BYTES  (`MT_BEATS * `MT_BEAT_BYTES)

// command field widths
`define MT_BLK_W        8
`define MT_START_W      20

// fixed AXI fields, INCR bursts and full strobes
`define MT_ID           0
`define MT_BURST_INCR   1
`define MT_WSTRB        {(`MT_DATA_W / 8){1'b1}}

`endif

// File: memtest_pkg.sv
/*
 * Types for the tester itself: pattern opcodes, controller states,
 * the run setup and the reported result.
 */
`include "memtest_params.svh"

package memtest_pkg;

   ////////////////////////////////////////////////////
   // opcodes and states
   ////////////////////////////////////////////////////

   // data pattern written and checked
   typedef enum logic [1:0] {
      PAT_INC,
      PAT_DEC,
      PAT_A,
      PAT_5
   } mt_pattern_e;

   // one controller covers all channels, only one is active at a time
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR_ADDR,
      ST_WR_DATA,
      ST_WR_RESP,
      ST_RD_ADDR,
      ST_RD_DATA,
      ST_DONE
   } mt_state_e;

   ////////////////////////////////////////////////////
   // setup and result
   ////////////////////////////////////////////////////

   // blk_size of 0 means 256 bursts
   typedef struct packed {
      mt_pattern_e              pattern;
      logic [`MT_START_W-1:0]   start;
      logic [`MT_BLK_W-1:0]     blk_size;
   } mt_cfg_t;

   typedef struct packed {
      logic                     init_done;
      logic                     test_done;
      logic                     test_err;
      logic [`MT_ADDR_W-1:0]    err_loc;
   } mt_status_t;

endpackage

// File: axi_pkg.sv
/*
 * AXI channel bundles used by the master. Fixed fields (len, size,
 * burst, ids, strobes) live in the params header, not here.
 */
`include "memtest_params.svh"

package axi_pkg;

   ////////////////////////////////////////////////////
   // request side
   ////////////////////////////////////////////////////

   // shared by AW and AR
   typedef struct packed {
      logic                     valid;
      logic [`MT_ADDR_W-1:0]    addr;
   } axi_addr_t;

   typedef struct packed {
      logic                     valid;
      logic [`MT_DATA_W-1:0]    data;
      logic                     last;
   } axi_w_t;

   ////////////////////////////////////////////////////
   // return side
   ////////////////////////////////////////////////////

   // rresp and rid are not used
   typedef struct packed {
      logic                     valid;
      logic [`MT_DATA_W-1:0]    data;
      logic                     last;
   } axi_r_t;

endpackage

// File: burst_counter.sv
/*
 * Beat and burst counters plus the running burst address.
 * Loaded at the start of a run, stepped by the controller on handshakes.
 */
`include "memtest_params.svh"

module burst_counter import memtest_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  resetn_i,
   input  logic                  load_i,
   input  logic                  beat_step_i,
   input  logic                  burst_step_i,
   input  mt_cfg_t               cfg_i,
   output logic                  last_beat_o,
   output logic                  last_burst_o,
   output logic [`MT_ADDR_W-1:0] burst_addr_o,
   output logic [`MT_ADDR_W-1:0] beat_addr_o
);

   localparam int BEAT_W = $clog2(`MT_BEATS);
   localparam logic [`MT_ADDR_W-1:0] BURST_BYTES = `MT_BURST_BYTES;
   localparam logic [`MT_ADDR_W-1:0] BEAT_BYTES  = `MT_BEAT_BYTES;

   logic [BEAT_W-1:0]     beat_cnt_q;
   logic [`MT_BLK_W-1:0]  burst_cnt_q;
   logic [`MT_BLK_W-1:0]  burst_max;
   logic [`MT_ADDR_W-1:0] addr_q;

   // size 0 wraps to all ones, i.e. 256 bursts
   assign burst_max = cfg_i.blk_size - 1'b1;

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         beat_cnt_q  <= '0;
         burst_cnt_q <= '0;
         addr_q      <= '0;
      end
      else if (load_i)
      begin
         beat_cnt_q  <= '0;
         burst_cnt_q <= '0;
         // burst aligned start
         addr_q      <= `MT_ADDR_W'(cfg_i.start) * BURST_BYTES;
      end
      else
      begin
         // beat count wraps by itself at the end of a burst
         if (beat_step_i)
            beat_cnt_q <= beat_cnt_q + 1'b1;
         if (burst_step_i)
         begin
            burst_cnt_q <= burst_cnt_q + 1'b1;
            addr_q      <= addr_q + BURST_BYTES;
         end
      end
   end

   assign last_beat_o  = (beat_cnt_q == BEAT_W'(`MT_BEATS - 1));
   assign last_burst_o = (burst_cnt_q == burst_max);
   assign burst_addr_o = addr_q;
   // byte address of the beat now on the bus
   assign beat_addr_o  = addr_q + `MT_ADDR_W'(beat_cnt_q) * BEAT_BYTES;

endmodule

// File: pattern_gen.sv
/*
 * Pattern word for the current beat. Seeded from the start index at the
 * start of a run and stepped once per accepted beat, for writes and reads alike.
 */
`include "memtest_params.svh"

module pattern_gen import memtest_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  resetn_i,
   input  logic                  load_i,
   input  logic                  step_i,
   input  mt_cfg_t               cfg_i,
   output logic [`MT_DATA_W-1:0] word_o
);

   localparam int HALF_W = `MT_DATA_W / 2;

   logic [HALF_W-1:0] upper_q;
   logic [HALF_W-1:0] lower_q;
   logic [HALF_W-1:0] base;

   // start index shifted by 8, kept to 28 bits
   // gives unique data per start block
   assign base = HALF_W'({4'h0, cfg_i.start, 8'h00});

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         upper_q <= '0;
         lower_q <= '0;
      end
      else if (load_i)
      begin
         case (cfg_i.pattern)
            PAT_INC:
            begin
               upper_q <= base - HALF_W'(1);
               lower_q <= base - HALF_W'(2);
            end
            PAT_DEC:
            begin
               upper_q <= base + HALF_W'('h101);
               lower_q <= base + HALF_W'('h102);
            end
            PAT_A:
            begin
               upper_q <= {(HALF_W / 4){4'hA}};
               lower_q <= {(HALF_W / 4){4'hA}};
            end
            default:
            begin
               upper_q <= {(HALF_W / 4){4'h5}};
               lower_q <= {(HALF_W / 4){4'h5}};
            end
         endcase
      end
      else if (step_i)
      begin
         // constant patterns simply hold
         if (cfg_i.pattern == PAT_INC)
         begin
            upper_q <= upper_q + HALF_W'(2);
            lower_q <= lower_q + HALF_W'(2);
         end
         else if (cfg_i.pattern == PAT_DEC)
         begin
            upper_q <= upper_q - HALF_W'(2);
            lower_q <= lower_q - HALF_W'(2);
         end
      end
   end

   assign word_o = {upper_q, lower_q};

endmodule

// File: read_checker.sv
/*
 * Compares returned read beats with the expected pattern word.
 * Keeps a sticky error flag and the byte address of the first bad beat.
 */
`include "memtest_params.svh"

module read_checker
(
   input  logic                  clk_i,
   input  logic                  resetn_i,
   input  logic                  start_i,
   input  logic                  beat_i,
   input  logic [`MT_DATA_W-1:0] rdata_i,
   input  logic [`MT_DATA_W-1:0] expect_i,
   input  logic [`MT_ADDR_W-1:0] beat_addr_i,
   output logic                  err_o,
   output logic [`MT_ADDR_W-1:0] err_loc_o
);

   logic                  err_q;
   logic [`MT_ADDR_W-1:0] err_loc_q;
   logic                  mismatch;

   ////////////////////////////////////////////////////
   // compare
   ////////////////////////////////////////////////////

   // only the first bad beat counts
   assign mismatch = beat_i && !err_q && (rdata_i != expect_i);

   ////////////////////////////////////////////////////
   // error state
   ////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         err_q     <= 1'b0;
         err_loc_q <= '0;
      end
      else if (start_i)
      begin
         // new test run, drop old result
         err_q     <= 1'b0;
         err_loc_q <= '0;
      end
      else if (mismatch)
      begin
         err_q     <= 1'b1;
         err_loc_q <= beat_addr_i;
      end
   end

   // both held until the next test command
   assign err_o     = err_q;
   assign err_loc_o = err_loc_q;

endmodule

// File: memtest_ctrl.sv
/*
 * Run controller. Walks through address, data and response phases for
 * every burst of an init or test run and raises the counter steps on handshakes.
 */
`include "memtest_params.svh"

module memtest_ctrl import memtest_pkg::*, axi_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  resetn_i,
   input  logic                  mem_init_i,
   input  logic                  mem_test_i,
   input  logic                  bvalid_i,
   input  logic                  awready_i,
   input  logic                  wready_i,
   input  logic                  arready_i,
   input  logic                  r_valid_i,
   input  logic                  r_last_i,
   input  logic                  last_beat_i,
   input  logic                  last_burst_i,
   input  logic                  err_i,
   input  logic [`MT_ADDR_W-1:0] burst_addr_i,
   input  logic [`MT_DATA_W-1:0] word_i,
   output axi_addr_t             aw_o,
   output axi_addr_t             ar_o,
   output axi_w_t                w_o,
   output logic                  rready_o,
   output logic                  cnt_load_o,
   output logic                  beat_step_o,
   output logic                  burst_step_o,
   output logic                  pat_load_o,
   output logic                  pat_step_o,
   output logic                  chk_start_o,
   output logic                  chk_beat_o,
   output logic                  init_done_o,
   output logic                  test_done_o
);

   mt_state_e state_q;
   mt_state_e state_d;
   // set for a test run, clear for init
   logic      test_q;
   logic      test_d;
   logic      start_init;
   logic      start_test;
   logic      w_hs;
   logic      r_hs;

   ////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      test_d  = test_q;
      case (state_q)
         ST_IDLE:
         begin
            // init wins over test
            if (mem_init_i)
            begin
               state_d = ST_WR_ADDR;
               test_d  = 1'b0;
            end
            else if (mem_test_i)
            begin
               state_d = ST_RD_ADDR;
               test_d  = 1'b1;
            end
         end
         ST_WR_ADDR:
            if (awready_i)
               state_d = ST_WR_DATA;
         ST_WR_DATA:
            if (wready_i && last_beat_i)
               state_d = ST_WR_RESP;
         // bresp is not looked at
         ST_WR_RESP:
            if (bvalid_i)
               state_d = last_burst_i ? ST_DONE : ST_WR_ADDR;
         ST_RD_ADDR:
         begin
            // error seen on the last beat of the previous burst
            if (err_i)
               state_d = ST_DONE;
            else if (arready_i)
               state_d = ST_RD_DATA;
         end
         ST_RD_DATA:
            if (r_valid_i && r_last_i)
               state_d = (last_burst_i || err_i) ? ST_DONE : ST_RD_ADDR;
         ST_DONE:
            state_d = ST_IDLE;
         default:
            state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         state_q <= ST_IDLE;
         test_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         test_q  <= test_d;
      end
   end

   ////////////////////////////////////////////////////
   // AXI side
   ////////////////////////////////////////////////////

   // payload comes from registers that only move on handshakes
   assign aw_o = '{valid: (state_q == ST_WR_ADDR), addr: burst_addr_i};
   assign w_o  = '{valid: (state_q == ST_WR_DATA),
                   data:  word_i,
                   last:  (state_q == ST_WR_DATA) && last_beat_i};
   // err_i cannot change while waiting here, so valid stays up once raised
   assign ar_o = '{valid: (state_q == ST_RD_ADDR) && !err_i, addr: burst_addr_i};
   assign rready_o = (state_q == ST_RD_DATA);

   assign w_hs = w_o.valid && wready_i;
   assign r_hs = rready_o && r_valid_i;

   ////////////////////////////////////////////////////
   // datapath controls
   ////////////////////////////////////////////////////

   assign start_init = (state_q == ST_IDLE) && mem_init_i;
   assign start_test = (state_q == ST_IDLE) && !mem_init_i && mem_test_i;

   assign cnt_load_o  = start_init || start_test;
   assign pat_load_o  = start_init || start_test;
   assign chk_start_o = start_test;

   // no step under back-pressure
   assign beat_step_o = w_hs || r_hs;
   assign pat_step_o  = w_hs || r_hs;
   assign chk_beat_o  = r_hs;

   // next burst only when another one follows
   assign burst_step_o = ((state_q == ST_WR_RESP) && bvalid_i && !last_burst_i) ||
                         (r_hs && r_last_i && !last_burst_i && !err_i);

   // one cycle done pulses
   assign init_done_o = (state_q == ST_DONE) && !test_q;
   assign test_done_o = (state_q == ST_DONE) && test_q;

endmodule

// File: memtest_top.sv
/*
 * Memory pattern generator and checker, an AXI master with one burst
 * in flight. Strobe mem_init_i to fill a block, mem_test_i to check it.
 */
`include "memtest_params.svh"

module memtest_top import memtest_pkg::*, axi_pkg::*;
(
   input  logic       clk_i,
   input  logic       resetn_i,
   input  mt_cfg_t    cfg_i,
   input  logic       mem_init_i,
   input  logic       mem_test_i,
   // write side
   output axi_addr_t  aw_o,
   input  logic       awready_i,
   output axi_w_t     w_o,
   input  logic       wready_i,
   input  logic       bvalid_i,
   // read side
   output axi_addr_t  ar_o,
   input  logic       arready_i,
   input  axi_r_t     r_i,
   output logic       rready_o,
   output mt_status_t status_o
);

   logic                  cnt_load;
   logic                  beat_step;
   logic                  burst_step;
   logic                  pat_load;
   logic                  pat_step;
   logic                  chk_start;
   logic                  chk_beat;
   logic                  last_beat;
   logic                  last_burst;
   logic                  err;
   logic                  init_done;
   logic                  test_done;
   logic [`MT_ADDR_W-1:0] burst_addr;
   logic [`MT_ADDR_W-1:0] beat_addr;
   logic [`MT_ADDR_W-1:0] err_loc;
   logic [`MT_DATA_W-1:0] word;

   ////////////////////////////////////////////////////
   // controller
   ////////////////////////////////////////////////////

   memtest_ctrl u_ctrl (
      .clk_i        (clk_i),
      .resetn_i     (resetn_i),
      .mem_init_i   (mem_init_i),
      .mem_test_i   (mem_test_i),
      .bvalid_i     (bvalid_i),
      .awready_i    (awready_i),
      .wready_i     (wready_i),
      .arready_i    (arready_i),
      .r_valid_i    (r_i.valid),
      .r_last_i     (r_i.last),
      .last_beat_i  (last_beat),
      .last_burst_i (last_burst),
      .err_i        (err),
      .burst_addr_i (burst_addr),
      .word_i       (word),
      .aw_o         (aw_o),
      .ar_o         (ar_o),
      .w_o          (w_o),
      .rready_o     (rready_o),
      .cnt_load_o   (cnt_load),
      .beat_step_o  (beat_step),
      .burst_step_o (burst_step),
      .pat_load_o   (pat_load),
      .pat_step_o   (pat_step),
      .chk_start_o  (chk_start),
      .chk_beat_o   (chk_beat),
      .init_done_o  (init_done),
      .test_done_o  (test_done)
   );

   ////////////////////////////////////////////////////
   // datapath
   ////////////////////////////////////////////////////

   burst_counter u_cnt (
      .clk_i        (clk_i),
      .resetn_i     (resetn_i),
      .load_i       (cnt_load),
      .beat_step_i  (beat_step),
      .burst_step_i (burst_step),
      .cfg_i        (cfg_i),
      .last_beat_o  (last_beat),
      .last_burst_o (last_burst),
      .burst_addr_o (burst_addr),
      .beat_addr_o  (beat_addr)
   );

   // same generator feeds write data and read expectation
   pattern_gen u_pat (
      .clk_i    (clk_i),
      .resetn_i (resetn_i),
      .load_i   (pat_load),
      .step_i   (pat_step),
      .cfg_i    (cfg_i),
      .word_o   (word)
   );

   read_checker u_chk (
      .clk_i       (clk_i),
      .resetn_i    (resetn_i),
      .start_i     (chk_start),
      .beat_i      (chk_beat),
      .rdata_i     (r_i.data),
      .expect_i    (word),
      .beat_addr_i (beat_addr),
      .err_o       (err),
      .err_loc_o   (err_loc)
   );

   assign status_o = '{init_done: init_done,
                       test_done: test_done,
                       test_err:  err,
                       err_loc:   err_loc};

endmodule

// File: memtest_chk.sv
/*
 * Protocol assertions on the AXI master ports and the done pulses.
 * Bound to memtest_top from the testbench.
 */
`include "memtest_params.svh"

module memtest_chk import memtest_pkg::*, axi_pkg::*;
(
   input logic       clk_i,
   input logic       resetn_i,
   input axi_addr_t  aw_o,
   input logic       awready_i,
   input axi_w_t     w_o,
   input logic       wready_i,
   input axi_addr_t  ar_o,
   input logic       arready_i,
   input mt_status_t status_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LAST_BEAT = `MT_BEATS - 1;

   logic [$clog2(`MT_BEATS)-1:0] w_cnt_q;
   int                           fail_cnt = 0;

   // W beats within the current burst
   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
         w_cnt_q <= '0;
      else if (w_o.valid && wready_i)
         w_cnt_q <= w_cnt_q + 1'b1;
   end

   //////////////////////////////////////////////////
   // valid held with stable payload
   //////////////////////////////////////////////////

   aw_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
      aw_o.valid && !awready_i |=> aw_o.valid && $stable(aw_o.addr))
      else
      begin
         fail_cnt++;
         $error("AW valid or address moved before awready");
      end

   ar_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
      ar_o.valid && !arready_i |=> ar_o.valid && $stable(ar_o.addr))
      else
      begin
         fail_cnt++;
         $error("AR valid or address moved before arready");
      end

   w_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
      w_o.valid && !wready_i |=> w_o.valid && $stable(w_o))
      else
      begin
         fail_cnt++;
         $error("W valid or beat moved before wready");
      end

   // last only on the final beat of a burst
   w_last: assert property (@(posedge clk_i) disable iff (!resetn_i)
      w_o.valid |-> (w_o.last == (w_cnt_q == LAST_BEAT)))
      else
      begin
         fail_cnt++;
         $error("w_o.last out of place");
      end

   //////////////////////////////////////////////////
   // done pulses
   //////////////////////////////////////////////////

   init_pulse: assert property (@(posedge clk_i) disable iff (!resetn_i)
      status_o.init_done |=> !status_o.init_done)
      else
      begin
         fail_cnt++;
         $error("init_done longer than one cycle");
      end

   test_pulse: assert property (@(posedge clk_i) disable iff (!resetn_i)
      status_o.test_done |=> !status_o.test_done)
      else
      begin
         fail_cnt++;
         $error("test_done longer than one cycle");
      end

endmodule

// File: memtest_top_tb.sv
/*
 * Testbench for the memory pattern tester. An AXI slave model with random
 * stalls stores the writes; a reference model checks every write, read address
 * and the final status. Protocol assertions come in through a bind.
 */
`include "memtest_params.svh"

module memtest_top_tb import memtest_pkg::*, axi_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   // 4 patterns x (init, clean test, corrupted test), at most 4 bursts each
   localparam int RUNS           = 12;
   localparam int MAX_BEATS      = RUNS * 4 * `MT_BEATS;
   localparam int TIMEOUT_CYCLES = MAX_BEATS * 20 + 1000;

   logic                  clk_i;
   logic                  resetn_i;
   mt_cfg_t               cfg_i;
   logic                  mem_init_i;
   logic                  mem_test_i;
   axi_addr_t             aw_o;
   logic                  awready_i;
   axi_w_t                w_o;
   logic                  wready_i;
   logic                  bvalid_i;
   axi_addr_t             ar_o;
   logic                  arready_i;
   axi_r_t                r_i;
   logic                  rready_o;
   mt_status_t            status_o;

   // slave memory, one entry per beat address
   logic [`MT_DATA_W-1:0] mem [logic [`MT_ADDR_W-1:0]];
   logic [`MT_ADDR_W-1:0] wr_addr;
   logic [`MT_ADDR_W-1:0] rd_addr;
   int                    wr_beat;
   int                    rd_beat;
   int                    wr_n;
   int                    rd_n;
   logic                  rd_active;
   logic                  r_hs;

   logic [31:0]           lfsr_q = 32'h6de5_7a21;
   int                    init_cnt = 0;
   int                    test_cnt = 0;
   logic                  done_err;
   logic [`MT_ADDR_W-1:0] done_loc;

   memtest_top uut (.*);

   bind memtest_top memtest_chk u_proto_chk (.*);

   //////////////////////////////////////////////////
   // helpers and reference model
   //////////////////////////////////////////////////

   // galois lfsr, one step per bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
      end
      return v;
   endfunction

   // nth beat of a run, straight from the pattern rules
   function automatic logic [`MT_DATA_W-1:0] exp_word(input mt_cfg_t c, input int n);
      logic [31:0] base;
      logic [31:0] n2;
      base = {4'h0, c.start, 8'h00};
      n2   = 32'(2 * n);
      case (c.pattern)
         PAT_INC: return {base - 32'd1 + n2, base - 32'd2 + n2};
         PAT_DEC: return {base + 32'h101 - n2, base + 32'h102 - n2};
         PAT_A:   return {16{4'hA}};
         default: return {16{4'h5}};
      endcase
   endfunction

   // blocks are contiguous, so beat n sits 8n bytes past the start
   function automatic logic [`MT_ADDR_W-1:0] beat_addr(input mt_cfg_t c, input int n);
      return `MT_ADDR_W'(c.start) * `MT_BURST_BYTES + `MT_ADDR_W'(n) * `MT_BEAT_BYTES;
   endfunction

   function automatic int total_beats(input mt_cfg_t c);
      return ((c.blk_size == 0) ? 256 : int'(c.blk_size)) * `MT_BEATS;
   endfunction

   function automatic logic [`MT_DATA_W-1:0] mem_word(input logic [`MT_ADDR_W-1:0] a);
      return mem.exists(a) ? mem[a] : '0;
   endfunction

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Testbench failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // one command, a stray opposite strobe mid-run, then wait for done
   task automatic run_cmd(input logic test_run);
      int init_before;
      int test_before;
      init_before = init_cnt;
      test_before = test_cnt;
      wr_n        = 0;
      rd_n        = 0;
      @(posedge clk_i);
      mem_init_i <= !test_run;
      mem_test_i <= test_run;
      @(posedge clk_i);
      mem_init_i <= 1'b0;
      mem_test_i <= 1'b0;
      repeat (4) @(posedge clk_i);
      mem_init_i <= test_run;
      mem_test_i <= !test_run;
      @(posedge clk_i);
      mem_init_i <= 1'b0;
      mem_test_i <= 1'b0;
      while (init_cnt == init_before && test_cnt == test_before)
         @(posedge clk_i);
      repeat (3) @(posedge clk_i);
      compare("status_o.init_done pulses", init_cnt, init_before + (test_run ? 0 : 1));
      compare("status_o.test_done pulses", test_cnt, test_before + (test_run ? 1 : 0));
   endtask

   //////////////////////////////////////////////////
   // clock, done monitor, slave model
   //////////////////////////////////////////////////

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
   begin
      if (resetn_i && status_o.init_done)
         init_cnt <= init_cnt + 1;
      if (resetn_i && status_o.test_done)
      begin
         test_cnt <= test_cnt + 1;
         done_err <= status_o.test_err;
         done_loc <= status_o.err_loc;
      end
   end

   always @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         awready_i <= 1'b0;
         wready_i  <= 1'b0;
         arready_i <= 1'b0;
         bvalid_i  <= 1'b0;
         r_i       <= '0;
         rd_active = 1'b0;
      end
      else
      begin
         // readies high about three cycles in four
         awready_i <= (rand_bits(2) != 0);
         wready_i  <= (rand_bits(2) != 0);
         arready_i <= (rand_bits(2) != 0);
         bvalid_i  <= 1'b0;
         if (aw_o.valid && awready_i)
         begin
            compare("aw inside block", wr_n < total_beats(cfg_i), 1);
            compare("aw_o.addr", aw_o.addr, beat_addr(cfg_i, wr_n));
            wr_addr = aw_o.addr;
            wr_beat = 0;
         end
         if (w_o.valid && wready_i)
         begin
            compare("w_o.data", w_o.data, exp_word(cfg_i, wr_n));
            compare("w_o.last", w_o.last, wr_beat == `MT_BEATS - 1);
            mem[wr_addr + wr_beat * `MT_BEAT_BYTES] = w_o.data;
            // response right after the last beat
            if (w_o.last)
               bvalid_i <= 1'b1;
            wr_beat++;
            wr_n++;
         end
         if (ar_o.valid && arready_i)
         begin
            compare("ar_o.addr", ar_o.addr, beat_addr(cfg_i, rd_n));
            rd_addr   = ar_o.addr;
            rd_beat   = 0;
            rd_active = 1'b1;
         end
         r_hs = r_i.valid && rready_o;
         if (r_hs)
         begin
            rd_beat++;
            rd_n++;
            if (r_i.last)
               rd_active = 1'b0;
         end
         // beat on offer stays put until taken, random gaps otherwise
         if (!r_i.valid || r_hs)
         begin
            if (rd_active && rand_bits(2) != 0)
               r_i <= '{valid: 1'b1,
                        data:  mem_word(rd_addr + rd_beat * `MT_BEAT_BYTES),
                        last:  rd_beat == `MT_BEATS - 1};
            else
               r_i <= '0;
         end
      end
   end

   //////////////////////////////////////////////////
   // watchdog
   //////////////////////////////////////////////////

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk_i);
      $display("timeout: runs did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial
   begin
      int                    pat_off;
      int                    bad_n;
      logic [`MT_ADDR_W-1:0] bad_addr;
      mt_cfg_t               c;
      cfg_i      = '0;
      mem_init_i = 1'b0;
      mem_test_i = 1'b0;
      resetn_i   = 1'b0;
      awready_i  = 1'b0;
      wready_i   = 1'b0;
      arready_i  = 1'b0;
      bvalid_i   = 1'b0;
      r_i        = '0;
      repeat (3) @(posedge clk_i);
      resetn_i <= 1'b1;
      @(posedge clk_i);
      // everything quiet out of reset
      compare("aw_o.valid", aw_o.valid, 0);
      compare("w_o.valid", w_o.valid, 0);
      compare("ar_o.valid", ar_o.valid, 0);
      compare("rready_o", rready_o, 0);
      compare("status_o.init_done", status_o.init_done, 0);
      compare("status_o.test_done", status_o.test_done, 0);
      compare("status_o.test_err", status_o.test_err, 0);
      @(negedge clk_i);
      pat_off = int'(rand_bits(2));
      for (int p = 0; p < 4; p++)
      begin
         // draw between edges so the slave owns the lfsr at posedge
         @(negedge clk_i);
         c.pattern  = mt_pattern_e'((p + pat_off) % 4);
         c.start    = `MT_START_W'(rand_bits(4));
         c.blk_size = `MT_BLK_W'(rand_bits(2) + 1);
         @(posedge clk_i);
         cfg_i <= c;
         run_cmd(1'b0);
         compare("beats written", wr_n, total_beats(c));
         run_cmd(1'b1);
         compare("status_o.test_err", done_err, 0);
         compare("beats read", rd_n, total_beats(c));
         // flip one bit of one beat
         @(negedge clk_i);
         bad_n         = int'(rand_bits(8)) % total_beats(c);
         bad_addr      = beat_addr(c, bad_n);
         mem[bad_addr] = mem_word(bad_addr) ^ (64'd1 << rand_bits(6));
         run_cmd(1'b1);
         compare("status_o.test_err", done_err, 1);
         compare("status_o.err_loc", done_loc, bad_addr);
      end
      if (uut.u_proto_chk.fail_cnt == 0)
      begin
         $display("Testbench passed");
         $finish;
      end
      else
      begin
         $display("protocol assertions failed during the run");
         $display("Testbench failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

// File: memtest_top.f
+incdir+.
memtest_pkg.sv
axi_pkg.sv
burst_counter.sv
pattern_gen.sv
read_checker.sv
memtest_ctrl.sv
memtest_top.sv
memtest_chk.sv
memtest_top_tb.sv

// File: Bender.yml
package:
  name: memtest

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - memtest_pkg.sv
      - axi_pkg.sv
      - burst_counter.sv
      - pattern_gen.sv
      - read_checker.sv
      - memtest_ctrl.sv
      - memtest_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - memtest_chk.sv
      - memtest_top_tb.sv
